/* tests/datapath_stimulus.txt */
# Columns: test number, opcode, data byte in hex, expected result byte in hex
# An expected value of -- means the result is not compared
1 READA 00 5A
1 READB 00 A5
1 READF 00 00
2 LOADA 3C --
2 LOADB C3 --
2 READA 00 3C
2 READB 00 C3
2 LOADA 7E --
2 READB 00 C3
3 ADD 00 --
3 READA 00 41
3 READF 00 01
3 LOADA 80 --
3 LOADB 80 --
3 ADD 00 --
3 READA 00 00
3 READF 00 03
4 LOADA 50 --
4 LOADB 30 --
4 SUB 00 --
4 READA 00 20
4 READF 00 01
4 LOADA 30 --
4 SUB 00 --
4 READA 00 00
4 READF 00 03
4 LOADA 10 --
4 SUB 00 --
4 READA 00 E0
4 READF 00 00
5 LOADA F0 --
5 LOADB 21 --
5 ORLOAD 40 --
5 READA 00 51
5 READB 00 21
5 READF 00 00
6 READB 00 21
6 LOADB 5A --
6 READB 00 5A
6 READA 00 51

/* filelist.f */
+incdir+include
hdl/busPkg.sv
hdl/ctrlPkg.sv
hdl/busRegister.sv
hdl/arithUnit.sv
hdl/transferSequencer.sv
hdl/busDatapath.sv
tests/tbBusDatapath.sv

/* Bender.yml */
package:
  name: bus_datapath

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/busPkg.sv
      - hdl/ctrlPkg.sv
      - hdl/busRegister.sv
      - hdl/arithUnit.sv
      - hdl/transferSequencer.sv
      - hdl/busDatapath.sv
  - target: test
    files:
      - tests/tbBusDatapath.sv

/* tests/tbBusDatapath.sv */
// Run from the project root, the stimulus path is relative; idle gaps are random but bounded
`timescale 1ns/10ps

module tbBusDatapath
  import busPkg::*;
  import ctrlPkg::*;
();

  localparam time CLK_PERIOD = 40ns;
  localparam time DRIVE_DELAY = 2ns;
  localparam int RESET_CYCLES = 16;
  // Worst case per command is three edges to ack, one hold, one to drop ack and two idle
  localparam int CYCLES_PER_CMD = 8;
  localparam int TIMEOUT_MARGIN = 50;
  // Edges from the accepting edge until ack is seen high
  localparam int ACK_LATENCY = 2;
  localparam int unsigned SEED = 32'h19d5_c504;
  localparam string STIM_FILE = "tests/datapath_stimulus.txt";

  logic clk;
  logic nrst;
  logic req;
  commandT cmd;
  logic ack;
  busByteT result;

  // Command table, one entry per stimulus line
  int testQ [$];
  opcodeT opQ [$];
  busByteT dataQ [$];
  busByteT expQ [$];
  bit checkQ [$];

  int cycleCount;
  int cycleLimit;
  int testErrors;
  int totalErrors;
  int testsPassed;
  int testsFailed;

  busDatapath i_busDatapath (
    .clk(clk),
    .nrst(nrst),
    .req(req),
    .cmd(cmd),
    .ack(ack),
    .result(result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Every rising edge counts toward the watchdog
  always @(posedge clk)
  begin
    cycleCount++;
  end

  // Watchdog, armed once the command count is known
  initial
  begin
    wait ((cycleLimit > 0) && (cycleCount > cycleLimit));
    $display("Run stopped after %0d cycles, handshake never completed", cycleCount);
    $display("TEST FAILED");
    $finish;
  end

  // Outputs have settled here, inputs change away from the edge
  task automatic waitDrivePoint();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic reportMismatch(input string msg);
    testErrors++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  task automatic reportProblem(input string msg);
    testErrors++;
    $display("Handshake problem at %0t: %s", $time, msg);
  endtask

  function automatic bit lookupOpcode(input string name, output opcodeT op);
    lookupOpcode = 1'b1;
    op = LOADA;
    case (name)
      "LOADA": op = LOADA;
      "LOADB": op = LOADB;
      "ADD": op = ADD;
      "SUB": op = SUB;
      "ORLOAD": op = ORLOAD;
      "READA": op = READA;
      "READB": op = READB;
      "READF": op = READF;
      default: lookupOpcode = 1'b0;
    endcase
  endfunction

  // Lines hold test number, mnemonic, hex data and hex expected or --
  task automatic readStimulus();
    int fd;
    int fields;
    int testNum;
    string line;
    string opName;
    string expText;
    busByteT dataVal;
    busByteT expVal;
    opcodeT op;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      totalErrors++;
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        if ((line.len() > 1) && (line.getc(0) != "#"))
        begin
          fields = $sscanf(line, "%d %s %h %s", testNum, opName, dataVal, expText);
          if ((fields != 4) || !lookupOpcode(opName, op))
          begin
            $display("Stimulus line could not be understood: %s", line);
            totalErrors++;
          end
          else
          begin
            expVal = '0;
            if (expText != "--")
            begin
              void'($sscanf(expText, "%h", expVal));
            end
            testQ.push_back(testNum);
            opQ.push_back(op);
            dataQ.push_back(dataVal);
            expQ.push_back(expVal);
            checkQ.push_back(expText != "--");
          end
        end
      end
      $fclose(fd);
      if (opQ.size() == 0)
      begin
        $display("The stimulus file holds no commands");
        totalErrors++;
      end
    end
  endtask

  // One full four-phase transfer followed by a random idle gap
  task automatic runCommand(input opcodeT op, input busByteT data, input bit doCheck,
                            input busByteT expected);
    int edges;
    int holdCycles;
    int gapCycles;
    busByteT readValue;
    holdCycles = $urandom_range(1, 0);
    gapCycles = $urandom_range(2, 0);
    cmd.opcode = op;
    cmd.data = data;
    req = 1'b1;
    edges = 0;
    do
    begin
      waitDrivePoint();
      edges++;
      if (!ack)
      begin
        assert (result == '0)
        else reportMismatch($sformatf("result %h while ack is low", result));
      end
    end
    while (!ack);
    // First counted edge is the one that accepts req
    assert (edges == ACK_LATENCY + 1)
    else reportProblem($sformatf("%s acknowledged %0d edges after acceptance, not %0d",
                                 op.name(), edges - 1, ACK_LATENCY));
    readValue = result;
    if (doCheck)
    begin
      assert (readValue == expected)
      else reportMismatch($sformatf("%s returned %h, expected %h", op.name(), readValue,
                                    expected));
    end
    // Only reads may drive the result bus
    if (!(op inside {READA, READB, READF}))
    begin
      assert (readValue == '0)
      else reportMismatch($sformatf("%s drove %h onto the result bus", op.name(), readValue));
    end
    repeat (holdCycles)
    begin
      waitDrivePoint();
      assert (ack && (result == readValue))
      else reportProblem("ack or result changed while req was still high");
    end
    req = 1'b0;
    waitDrivePoint();
    assert (!ack)
    else reportProblem("ack did not fall one cycle after req was dropped");
    while (ack)
    begin
      waitDrivePoint();
    end
    assert (result == '0)
    else reportMismatch($sformatf("result %h after ack fell", result));
    repeat (gapCycles)
    begin
      waitDrivePoint();
      assert (!ack && (result == '0))
      else reportProblem("ack or result active while idle");
    end
  endtask

  task automatic finishTest(input int testNum, input int commands);
    if (testErrors == 0)
    begin
      testsPassed++;
    end
    else
    begin
      testsFailed++;
    end
    $display("Test %0d finished: %0d commands, %0d errors", testNum, commands, testErrors);
    totalErrors += testErrors;
    testErrors = 0;
  endtask

  initial
  begin
    int currentTest;
    int cmdsInTest;
    clk = 1'b0;
    nrst = 1'b0;
    req = 1'b0;
    cmd = '0;
    cycleCount = 0;
    cycleLimit = 0;
    testErrors = 0;
    totalErrors = 0;
    testsPassed = 0;
    testsFailed = 0;
    void'($urandom(SEED));
    readStimulus();
    cycleLimit = RESET_CYCLES + CYCLES_PER_CMD * opQ.size() + TIMEOUT_MARGIN;
    // Bus stays quiet for the whole reset
    repeat (RESET_CYCLES)
    begin
      waitDrivePoint();
      assert (!ack && (result == '0))
      else reportProblem("ack or result active during reset");
    end
    nrst = 1'b1;
    cmdsInTest = 0;
    currentTest = (opQ.size() > 0) ? testQ[0] : 0;
    for (int i = 0; i < opQ.size(); i++)
    begin
      if (testQ[i] != currentTest)
      begin
        finishTest(currentTest, cmdsInTest);
        currentTest = testQ[i];
        cmdsInTest = 0;
      end
      runCommand(opQ[i], dataQ[i], checkQ[i], expQ[i]);
      cmdsInTest++;
    end
    if (opQ.size() > 0)
    begin
      finishTest(currentTest, cmdsInTest);
    end
    $display("Tests passed: %0d, tests failed: %0d, errors: %0d", testsPassed, testsFailed,
             totalErrors);
    if ((totalErrors == 0) && (opQ.size() > 0))
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* hdl/busDatapath.sv */
// Top of the bus datapath; host drives one command per four-phase handshake, no back-pressure on result
`timescale 1ns/10ps

module busDatapath
  import busPkg::*;
  import ctrlPkg::*;
(
  input logic clk,
  input logic nrst,
  input logic req,
  input commandT cmd,
  output logic ack,
  // Zero unless a read command is being acknowledged
  output busByteT result
);

  `include "bus_params.svh"

  ctrlWordT ctrl;
  busByteT extData;
  aluResultT aluResult;
  busByteT aValue;
  busByteT bValue;

  // Register input and output bundles
  busByteT aInputs [2];
  busByteT bInputs [1];
  aluFlagsT flagsInputs [1];
  busByteT aBus [1];
  busByteT bBus [1];
  aluFlagsT flagsBus [1];

  // Input 0 external data, input 1 ALU byte
  assign aInputs[0] = extData;
  assign aInputs[1] = aluResult.value;
  assign bInputs[0] = extData;
  assign flagsInputs[0] = aluResult.flags;

  transferSequencer i_transferSequencer (
    .clk(clk),
    .nrst(nrst),
    .req(req),
    .cmd(cmd),
    .ack(ack),
    .ctrl(ctrl),
    .extData(extData)
  );

  busRegister #(
    .payloadT(busByteT),
    .INPUT_COUNT(2),
    .OUTPUT_COUNT(1),
    .DEFAULT_VALUE(`REG_A_DEFAULT)
  ) regA (
    .clk(clk),
    .nrst(nrst),
    .busInputs(aInputs),
    .readEnable({ctrl.aluToA, ctrl.extToA}),
    .writeEnable(ctrl.readSel[READ_SEL_A]),
    .busOutputs(aBus),
    .value(aValue)
  );

  busRegister #(
    .payloadT(busByteT),
    .INPUT_COUNT(1),
    .OUTPUT_COUNT(1),
    .DEFAULT_VALUE(`REG_B_DEFAULT)
  ) regB (
    .clk(clk),
    .nrst(nrst),
    .busInputs(bInputs),
    .readEnable(ctrl.extToB),
    .writeEnable(ctrl.readSel[READ_SEL_B]),
    .busOutputs(bBus),
    .value(bValue)
  );

  // Flags are only ever read through the gated output
  busRegister #(
    .payloadT(aluFlagsT),
    .INPUT_COUNT(1),
    .OUTPUT_COUNT(1),
    .DEFAULT_VALUE(`FLAGS_DEFAULT)
  ) regFlags (
    .clk(clk),
    .nrst(nrst),
    .busInputs(flagsInputs),
    .readEnable(ctrl.aluToFlags),
    .writeEnable(ctrl.readSel[READ_SEL_FLAGS]),
    .busOutputs(flagsBus),
    .value()
  );

  arithUnit i_arithUnit (
    .a(aValue),
    .b(bValue),
    .subtract(ctrl.subtract),
    .result(aluResult)
  );

  // Shared result bus, flags zero-extended into the low bits
  assign result = aBus[0] | bBus[0] | busByteT'(flagsBus[0]);

endmodule

/* hdl/transferSequencer.sv */
// Four-phase req/ack; cmd must stay stable while req is high, and a new req waits for ack low
`timescale 1ns/10ps

module transferSequencer
  import busPkg::*;
  import ctrlPkg::*;
(
  input logic clk,
  input logic nrst,
  input logic req,
  input commandT cmd,
  output logic ack,
  output ctrlWordT ctrl,
  // Latched data byte for the register inputs
  output busByteT extData
);

  typedef enum logic [1:0]
  {
    IDLE,
    EXEC,
    ACKN
  } seqStateT;

  seqStateT state;
  commandT cmdQ;
  ctrlWordT decoded;
  logic [2:0] readSelQ;

  // Capture the command at the accepting edge
  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && req)
    begin
      cmdQ <= cmd;
    end
  end

  // Opcode to enable pattern
  always_comb
  begin
    decoded = '0;
    case (cmdQ.opcode)
      LOADA:
      begin
        decoded.extToA = 1'b1;
      end
      LOADB:
      begin
        decoded.extToB = 1'b1;
      end
      ADD:
      begin
        decoded.aluToA = 1'b1;
        decoded.aluToFlags = 1'b1;
      end
      SUB:
      begin
        decoded.aluToA = 1'b1;
        decoded.aluToFlags = 1'b1;
        decoded.subtract = 1'b1;
      end
      // Both sources into A, merged by the register OR
      ORLOAD:
      begin
        decoded.extToA = 1'b1;
        decoded.aluToA = 1'b1;
      end
      READA:
      begin
        decoded.readSel[READ_SEL_A] = 1'b1;
      end
      READB:
      begin
        decoded.readSel[READ_SEL_B] = 1'b1;
      end
      READF:
      begin
        decoded.readSel[READ_SEL_FLAGS] = 1'b1;
      end
      default:
      begin
        decoded = '0;
      end
    endcase
  end

  // Idle, one execute cycle, then acknowledge until req drops
  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      state <= IDLE;
      ack <= 1'b0;
      readSelQ <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          // ack is always low here, so req is safe to accept
          if (req)
          begin
            state <= EXEC;
          end
        end
        EXEC:
        begin
          state <= ACKN;
        end
        ACKN:
        begin
          if (!ack)
          begin
            // Read select rises with ack so result stays zero while ack is low
            ack <= 1'b1;
            readSelQ <= decoded.readSel;
          end
          else if (!req)
          begin
            ack <= 1'b0;
            readSelQ <= '0;
            state <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Write enables live only in the execute cycle
  always_comb
  begin
    ctrl = (state == EXEC) ? decoded : ctrlWordT'('0);
    ctrl.readSel = readSelQ;
  end

  assign extData = cmdQ.data;

endmodule

/* hdl/arithUnit.sv */
// Purely combinational add/subtract; carry on subtract is the inverted borrow, no overflow flag
`timescale 1ns/10ps

module arithUnit
  import busPkg::*;
(
  input busByteT a,
  input busByteT b,
  // High selects a minus b
  input logic subtract,
  output aluResultT result
);

  localparam int WIDTH = $bits(busByteT);

  busByteT operandB;
  logic [WIDTH:0] sum;

  // Two's complement subtract as invert plus carry-in
  assign operandB = subtract ? ~b : b;

  // One extra bit keeps the carry out
  assign sum = {1'b0, a} + {1'b0, operandB} + {{WIDTH{1'b0}}, subtract};

  always_comb
  begin
    result.value = sum[WIDTH-1:0];
    // Ninth bit, so a set carry on SUB means no borrow
    result.flags.carry = sum[WIDTH];
    result.flags.zero = (sum[WIDTH-1:0] == '0);
  end

endmodule

/* hdl/busRegister.sv */
// Payload type must be packed; all enabled inputs are ORed together, outputs read zero when not enabled
`timescale 1ns/10ps

module busRegister
#(
  parameter type payloadT = logic [7:0],
  parameter int INPUT_COUNT = 1,
  parameter int OUTPUT_COUNT = 1,
  parameter payloadT DEFAULT_VALUE = '0
)
(
  input logic clk,
  input logic nrst,
  // Candidate sources, one per input enable
  input payloadT busInputs [INPUT_COUNT],
  // Latch enables, one per input
  input logic [INPUT_COUNT-1:0] readEnable,
  // Drive enables, one per gated output
  input logic [OUTPUT_COUNT-1:0] writeEnable,
  output payloadT busOutputs [OUTPUT_COUNT],
  // Always shows the stored value
  output payloadT value
);

  payloadT maskedInputs [INPUT_COUNT];
  payloadT candidate;
  payloadT storedValue;

  // Each input passes only while its enable is high
  always_comb
  begin
    for (int i = 0; i < INPUT_COUNT; i++)
    begin
      maskedInputs[i] = readEnable[i] ? busInputs[i] : payloadT'('0);
    end
  end

  // Several enabled sources merge bitwise
  always_comb
  begin
    candidate = payloadT'('0);
    for (int i = 0; i < INPUT_COUNT; i++)
    begin
      candidate = payloadT'(candidate | maskedInputs[i]);
    end
  end

  // Latch on any enabled input, otherwise hold
  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      storedValue <= DEFAULT_VALUE;
    end
    else if (|readEnable)
    begin
      storedValue <= candidate;
    end
  end

  // Gated copies for the shared result bus
  always_comb
  begin
    for (int i = 0; i < OUTPUT_COUNT; i++)
    begin
      busOutputs[i] = writeEnable[i] ? storedValue : payloadT'('0);
    end
  end

  // Ungated view for the arithmetic unit
  assign value = storedValue;

endmodule

/* hdl/ctrlPkg.sv */
// Control-side types; the command payload reuses the bus byte type, so compile busPkg first
package ctrlPkg;

  // Host opcodes, one per four-phase handshake
  typedef enum logic [3:0]
  {
    LOADA  = 4'd0,
    LOADB  = 4'd1,
    ADD    = 4'd2,
    SUB    = 4'd3,
    ORLOAD = 4'd4,
    READA  = 4'd5,
    READB  = 4'd6,
    READF  = 4'd7
  } opcodeT;

  // Command as presented on the host port
  typedef struct packed
  {
    opcodeT opcode;
    busPkg::busByteT data;
  } commandT;

  // Bit positions inside the one-hot read select
  localparam int READ_SEL_A = 0;
  localparam int READ_SEL_B = 1;
  localparam int READ_SEL_FLAGS = 2;

  // Control word fanned out from the sequencer to every register
  typedef struct packed
  {
    logic extToA;
    logic aluToA;
    logic extToB;
    logic aluToFlags;
    logic subtract;
    // One-hot, at most one register drives the result bus
    logic [2:0] readSel;
  } ctrlWordT;

endpackage

/* hdl/busPkg.sv */
// Data-side types of the bus; width comes from bus_params.svh, so the include dir must be set
package busPkg;

  `include "bus_params.svh"

  // One byte as carried on the data bus
  typedef logic [`BUS_WIDTH-1:0] busByteT;

  // Flags produced by the arithmetic unit
  // Zero sits in bit 1 and carry in bit 0 once zero-extended onto the bus
  typedef struct packed
  {
    logic zero;
    // For subtraction this means no borrow
    logic carry;
  } aluFlagsT;

  // Full arithmetic result, byte plus flags
  typedef struct packed
  {
    busByteT value;
    aluFlagsT flags;
  } aluResultT;

endpackage

/* include/bus_params.svh */
// Bus width and register reset values; reset values must fit the payload type of each register
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// Data bus width in bits
`define BUS_WIDTH 8

// Reset value of general register A
`define REG_A_DEFAULT 8'h5A

// Reset value of general register B
`define REG_B_DEFAULT 8'hA5

// Flags come out of reset with zero and carry both clear
`define FLAGS_DEFAULT 2'b00

`endif
